// File: cla_pkg.sv
package cla_pkg;

    localparam int operand_w = 8;   // adder operand width
    localparam int wb_data_w = 16;  // bus data width
    localparam int wb_addr_w = 2;   // word address width

    typedef logic signed [operand_w-1:0] operand_t;  // two's complement operand
    typedef logic [wb_data_w-1:0]        wb_data_t;
    typedef logic [wb_addr_w-1:0]        wb_addr_t;

    localparam wb_addr_t addr_a      = 2'd0;  // operand a, signed
    localparam wb_addr_t addr_b      = 2'd1;  // operand b, signed
    localparam wb_addr_t addr_ctrl   = 2'd2;  // control, saturation enable
    localparam wb_addr_t addr_result = 2'd3;  // result word, read only

    localparam int ctrl_sat_bit  = 0;   // saturation enable in ctrl
    localparam int res_ovf_bit   = 8;   // overflow flag in result word
    localparam int res_uvf_bit   = 9;   // underflow flag
    localparam int res_carry_bit = 10;  // unsigned carry out

    localparam operand_t sat_max = operand_t'(127);   // clamp on overflow
    localparam operand_t sat_min = operand_t'(-128);  // clamp on underflow

    typedef struct packed {
        logic     carry;  // ninth bit of unsigned sum
        logic     uvf;
        logic     ovf;
        operand_t sum;    // wrapped or clamped sum
    } result_t;

endpackage

// File: cla_add_if.sv
`timescale 1ns/1ns

interface cla_add_if;
    import cla_pkg::*;

    operand_t a;      // operand a, from register block
    operand_t b;      // operand b
    operand_t sum;    // raw wrapped sum from lookahead adder
    logic     carry;  // carry out of msb

    // register block owns the operands
    modport regs (
        output a, b
    );

    modport adder (
        input  a, b,
        output sum, carry
    );

    modport sat (
        input a, b, sum, carry
    );
endinterface

// File: cla_wb_regs.sv
`timescale 1ns/1ns

module cla_wb_regs (
    input  logic              clk_i,
    input  logic              rst_n,
    input  logic              cyc,     // wishbone cycle
    input  logic              stb,     // wishbone strobe
    input  logic              we,      // write enable
    input  cla_pkg::wb_addr_t adr,     // word address
    input  cla_pkg::wb_data_t dat_w,   // write data
    output cla_pkg::wb_data_t dat_r,   // read data, valid with ack
    output logic              ack,     // one cycle acknowledge
    cla_add_if.regs           ops,     // operands to adder and saturate
    output logic              sat_en,  // saturation enable
    input  cla_pkg::result_t  result   // registered result
);
    import cla_pkg::*;

    logic req;    // valid bus request
    logic wr_en;  // write strobe, first cycle of an access only

    assign req   = cyc & stb;
    assign wr_en = req & we & ~ack;  // no double write while ack is high

    // ack follows the request by one cycle, never two in a row
    always_ff @(posedge clk_i)
    begin
        if (!rst_n)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= req & ~ack;  // drops after one cycle even if stb held
        end
    end

    // operand and control registers
    always_ff @(posedge clk_i)
    begin
        if (!rst_n)
        begin
            ops.a  <= '0;
            ops.b  <= '0;
            sat_en <= 1'b0;
        end
        else if (wr_en)
        begin
            case (adr)
                addr_a:
                begin
                    ops.a <= operand_t'(dat_w[operand_w-1:0]);  // low byte only
                end
                addr_b:
                begin
                    ops.b <= operand_t'(dat_w[operand_w-1:0]);
                end
                addr_ctrl:
                begin
                    sat_en <= dat_w[ctrl_sat_bit];
                end
                addr_result:
                begin
                    // read only, write dropped
                end
            endcase
        end
    end

    // read mux, held stable by the master while ack is high
    always_comb
    begin
        dat_r = '0;  // unused bits read as zero
        case (adr)
            addr_a:
            begin
                dat_r = {{(wb_data_w-operand_w){ops.a[operand_w-1]}}, ops.a};  // sign extend
            end
            addr_b:
            begin
                dat_r = {{(wb_data_w-operand_w){ops.b[operand_w-1]}}, ops.b};
            end
            addr_ctrl:
            begin
                dat_r[ctrl_sat_bit] = sat_en;
            end
            addr_result:
            begin
                dat_r[res_carry_bit]  = result.carry;
                dat_r[res_uvf_bit]    = result.uvf;
                dat_r[res_ovf_bit]    = result.ovf;
                dat_r[operand_w-1:0] = result.sum;  // sum in low byte
            end
        endcase
    end

endmodule

// File: cla_lookahead_adder.sv
`timescale 1ns/1ns

module cla_lookahead_adder (
    cla_add_if.adder ops  // operands in, raw sum and carry out
);
    import cla_pkg::*;

    logic [operand_w-1:0] p;  // propagate per bit
    logic [operand_w-1:0] g;  // generate per bit
    logic [operand_w:0]   c;  // c[i] is carry into bit i

    // terms[i] are the product terms of carry c[i+1]
    // bit 0 is the carry-in path, bit j+1 starts at generate g[j]
    logic [operand_w-1:0][operand_w:0] terms;

    assign p    = ops.a | ops.b;  // a or b
    assign g    = ops.a & ops.b;  // a and b
    assign c[0] = 1'b0;           // no carry-in

    // full lookahead, every carry straight from p, g and c[0]
    for (genvar i = 0; i < operand_w; i++)
    begin : g_carry
        assign terms[i][0] = c[0] & (&p[i:0]);  // carry-in through all propagates

        for (genvar j = 0; j < operand_w; j++)
        begin : g_term
            if (j == i)
            begin : g_own
                assign terms[i][j+1] = g[j];  // own generate
            end
            else if (j < i)
            begin : g_lower
                assign terms[i][j+1] = g[j] & (&p[i:j+1]);  // lower generate, higher propagates
            end
            else
            begin : g_none
                assign terms[i][j+1] = 1'b0;  // bits above i do not feed c[i+1]
            end
        end

        assign c[i+1] = |terms[i];  // or of all product terms
    end

    // sum bits
    for (genvar k = 0; k < operand_w; k++)
    begin : g_sum
        assign ops.sum[k] = ops.a[k] ^ ops.b[k] ^ c[k];
    end

    assign ops.carry = c[operand_w];  // unsigned ninth bit

endmodule

// File: cla_saturate.sv
`timescale 1ns/1ns

module cla_saturate (
    input  logic             clk_i,
    input  logic             rst_n,
    cla_add_if.sat           ops,     // operands and raw sum
    input  logic             sat_en,  // clamp on ovf or uvf
    output cla_pkg::result_t result   // registered result word
);
    import cla_pkg::*;

    logic    ovf;       // two non-negative operands, negative sum
    logic    uvf;       // two negative operands, non-negative sum
    result_t result_d;  // next result

    assign ovf = ~ops.a[operand_w-1] & ~ops.b[operand_w-1] &  ops.sum[operand_w-1];
    assign uvf =  ops.a[operand_w-1] &  ops.b[operand_w-1] & ~ops.sum[operand_w-1];

    always_comb
    begin
        result_d.carry = ops.carry;  // carry never clamped
        result_d.uvf   = uvf;        // flags reported with or without clamp
        result_d.ovf   = ovf;
        result_d.sum   = ops.sum;    // wrapped sum by default
        if (sat_en && ovf)
        begin
            result_d.sum = sat_max;  // +127
        end
        else if (sat_en && uvf)
        begin
            result_d.sum = sat_min;  // -128
        end
    end

    // one register stage after the operand registers
    always_ff @(posedge clk_i)
    begin
        if (!rst_n)
        begin
            result <= '0;
        end
        else
        begin
            result <= result_d;
        end
    end

endmodule

// File: cla_wb_top.sv
`timescale 1ns/1ns

module cla_wb_top (
    input  logic              clk_i,
    input  logic              rst_n,
    input  logic              cyc,    // wishbone classic slave
    input  logic              stb,
    input  logic              we,
    input  cla_pkg::wb_addr_t adr,    // word address
    input  cla_pkg::wb_data_t dat_w,
    output cla_pkg::wb_data_t dat_r,
    output logic              ack
);
    import cla_pkg::*;

    result_t result;  // saturate stage to read mux
    logic    sat_en;  // ctrl register to saturate stage

    cla_add_if i_add_if ();  // operands and raw sum

    // bus side, operand and control registers
    cla_wb_regs i_wb_regs (
        .clk_i  (clk_i),
        .rst_n  (rst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack),
        .ops    (i_add_if.regs),
        .sat_en (sat_en),
        .result (result)
    );

    // combinational 8-bit lookahead adder
    cla_lookahead_adder i_adder (
        .ops (i_add_if.adder)
    );

    // flags, clamp, result register
    cla_saturate i_saturate (
        .clk_i  (clk_i),
        .rst_n  (rst_n),
        .ops    (i_add_if.sat),
        .sat_en (sat_en),
        .result (result)
    );

endmodule

// File: cla_wb_top_sva.sv
`timescale 1ns/1ns

module cla_wb_top_sva (
    input logic             clk_i,
    input logic             rst_n,
    input logic             cyc,
    input logic             stb,
    input logic             ack,
    input cla_pkg::result_t result  // registered result inside the top
);

    // ack only in the cycle after a request
    a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n)
        ack |-> $past(cyc && stb))
        else $error("ack without a request in the previous cycle");

    // single-cycle ack, even with stb held high
    a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n)
        ack |=> !ack)
        else $error("ack high for two cycles in a row");

    // same-sign operands cannot go both ways
    a_flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n)
        !(result.ovf && result.uvf))
        else $error("overflow and underflow flags set together");

endmodule

bind cla_wb_top cla_wb_top_sva i_sva (
    .clk_i  (clk_i),
    .rst_n  (rst_n),
    .cyc    (cyc),
    .stb    (stb),
    .ack    (ack),
    .result (result)
);

// File: tb_cla_wb_top.sv
`timescale 1ns/1ns

module tb_cla_wb_top;
    import cla_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 3;
    localparam int n_random     = 20;  // random pairs per test
    localparam int n_b2b        = 16;  // back-to-back pairs
    localparam int n_dir        = 5;   // directed wrap pairs
    localparam int access_bound = 4;   // cycles per access incl. idle
    localparam int n_accesses   = 4 + 11 + (1 + 3 * n_random) + (1 + 3 * n_dir)
                                + (1 + 3 * n_dir + 3 * n_random) + (1 + 3 * n_b2b);
    localparam int timeout_ns   = (reset_cycles + n_accesses * access_bound + 10) * clk_period;

    // 100+100, -100+-100, 127+1, -128+-1, -128+-128
    localparam operand_t dir_a [n_dir] = '{8'sh64, 8'sh9c, 8'sh7f, 8'sh80, 8'sh80};
    localparam operand_t dir_b [n_dir] = '{8'sh64, 8'sh9c, 8'sh01, 8'shff, 8'sh80};

    logic     clk_i;
    logic     rst_n;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     ack;
    int       errors;

    cla_wb_top i_cla_wb_top (
        .clk_i (clk_i),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial clk_i = 1'b0;
    always #(clk_period / 2) clk_i = ~clk_i;

    // expected result from the signed and unsigned sums
    function automatic result_t model_add(input operand_t a, input operand_t b, input logic sat);
        int                 s;  // true signed sum
        logic [operand_w:0] u;  // unsigned sum, ninth bit is carry
        result_t            r;
        s       = int'(a) + int'(b);
        u       = {1'b0, a} + {1'b0, b};
        r.carry = u[operand_w];
        r.ovf   = (s > 127);
        r.uvf   = (s < -128);
        r.sum   = operand_t'(u[operand_w-1:0]);  // wrapped
        if (sat && r.ovf)
        begin
            r.sum = 8'sh7f;
        end
        else if (sat && r.uvf)
        begin
            r.sum = 8'sh80;
        end
        return r;
    endfunction

    // split the bus word into result fields
    function automatic result_t word_to_result(input wb_data_t w);
        result_t r;
        r.sum   = operand_t'(w[operand_w-1:0]);
        r.ovf   = w[res_ovf_bit];
        r.uvf   = w[res_uvf_bit];
        r.carry = w[res_carry_bit];
        return r;
    endfunction

    task automatic stop_on_error(input string why);
        errors++;
        $display("** Error at %0t ns: %s", $time, why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
        if (got !== exp)
        begin
            stop_on_error($sformatf("%s: got 16'h%04h, expected 16'h%04h", what, got, exp));
        end
    endtask

    task automatic check_result(input result_t got, input result_t exp, input string what);
        if (got !== exp)
        begin
            stop_on_error($sformatf("%s: got sum %0d c%0b o%0b u%0b, %s %0d c%0b o%0b u%0b",
                what, got.sum, got.carry, got.ovf, got.uvf,
                "expected sum", exp.sum, exp.carry, exp.ovf, exp.uvf));
        end
    endtask

    // ack is due exactly one cycle after the request
    task automatic wait_ack;
        @(negedge clk_i);  // request not yet sampled
        if (ack !== 1'b0)
        begin
            stop_on_error("ack high before the request was sampled");
        end
        @(negedge clk_i);  // ack settled mid-cycle
        if (ack !== 1'b1)
        begin
            stop_on_error("no ack in the cycle after the request");
        end
    endtask

    // bus left requesting, next access or bus_idle follows
    task automatic wb_write(input wb_addr_t a, input wb_data_t d);
        @(posedge clk_i);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= d;
        wait_ack();
    endtask

    task automatic wb_read(input wb_addr_t a, output wb_data_t d);
        @(posedge clk_i);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b0;
        adr   <= a;
        dat_w <= '0;
        wait_ack();
        d = dat_r;  // valid while ack high
    endtask

    task automatic bus_idle;
        @(posedge clk_i);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    // result read, upper bits must stay zero
    task automatic read_result(output result_t r);
        wb_data_t w;
        wb_read(addr_result, w);
        check_data(w >> (res_carry_bit + 1), '0, "unused result bits");
        r = word_to_result(w);
    endtask

    task automatic add_and_check(input operand_t a, input operand_t b, input logic sat);
        result_t got;
        wb_write(addr_a, {8'h00, a});
        wb_write(addr_b, {8'h00, b});
        read_result(got);
        check_result(got, model_add(a, b, sat), $sformatf("%0d + %0d sat %0b", a, b, sat));
    endtask

    task automatic test_reset_values;
        wb_data_t d;
        $display("test: reset values");
        for (int i = 0; i < 4; i++)
        begin
            wb_read(wb_addr_t'(i), d);
            check_data(d, '0, $sformatf("reset value at address %0d", i));
        end
        bus_idle();
    endtask

    task automatic test_register_readback;
        wb_data_t d;
        result_t  got;
        $display("test: register readback");
        wb_write(addr_a, 16'h3c85);  // upper byte dropped
        wb_read(addr_a, d);
        check_data(d, 16'hff85, "a readback");
        wb_write(addr_b, 16'h807f);
        wb_read(addr_b, d);
        check_data(d, 16'h007f, "b readback");
        wb_write(addr_ctrl, 16'h0001);
        wb_read(addr_ctrl, d);
        check_data(d, 16'h0001, "ctrl readback set");
        wb_write(addr_ctrl, 16'hfffe);  // only the enable bit is stored
        wb_read(addr_ctrl, d);
        check_data(d, 16'h0000, "ctrl readback clear");
        read_result(got);
        check_result(got, model_add(8'sh85, 8'sh7f, 1'b0), "readback pair");
        wb_write(addr_result, 16'hffff);  // read only address
        read_result(got);
        check_result(got, model_add(8'sh85, 8'sh7f, 1'b0), "result after write to result address");
        bus_idle();
    endtask

    task automatic test_plain_add;
        operand_t a;
        operand_t b;
        $display("test: plain addition");
        wb_write(addr_ctrl, 16'h0000);
        bus_idle();
        repeat (n_random)
        begin
            a = operand_t'($urandom());
            b = operand_t'($urandom());
            add_and_check(a, b, 1'b0);
            bus_idle();
        end
    endtask

    task automatic test_wrap_flags;
        $display("test: overflow and underflow, wrapped");
        wb_write(addr_ctrl, 16'h0000);
        bus_idle();
        for (int i = 0; i < n_dir; i++)
        begin
            add_and_check(dir_a[i], dir_b[i], 1'b0);
            bus_idle();
        end
    endtask

    task automatic test_saturation;
        operand_t a;
        operand_t b;
        int       s;
        result_t  got;
        $display("test: saturation");
        wb_write(addr_ctrl, 16'h0001);
        bus_idle();
        for (int i = 0; i < n_dir; i++)
        begin
            add_and_check(dir_a[i], dir_b[i], 1'b1);  // clamped, flags kept
            bus_idle();
        end
        repeat (n_random)
        begin
            a = operand_t'($urandom());
            b = operand_t'($urandom());
            s = int'(a) + int'(b);
            while (s > 127 || s < -128)
            begin
                b = operand_t'(int'(b) / 2);  // shrink b toward zero
                s = int'(a) + int'(b);
            end
            wb_write(addr_a, {8'h00, a});
            wb_write(addr_b, {8'h00, b});
            read_result(got);
            check_result(got, model_add(a, b, 1'b0), $sformatf("unclamped %0d + %0d", a, b));
            bus_idle();
        end
    endtask

    task automatic test_back_to_back;
        operand_t a;
        operand_t b;
        logic     sat;
        $display("test: back-to-back accesses");
        sat = 1'($urandom());
        wb_write(addr_ctrl, {15'h0000, sat});
        repeat (n_b2b)
        begin
            a = operand_t'($urandom());
            b = operand_t'($urandom());
            add_and_check(a, b, sat);  // no idle cycle between accesses
        end
        bus_idle();
    endtask

    initial
    begin
        #(timeout_ns);
        $display("watchdog: run did not finish within %0d ns, a bus access is stuck", timeout_ns);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial
    begin
        rst_n  = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        errors = 0;
        void'($urandom(32'h66209cee));
        repeat (reset_cycles) @(posedge clk_i);
        rst_n <= 1'b1;
        test_reset_values();
        test_register_readback();
        test_plain_add();
        test_wrap_flags();
        test_saturation();
        test_back_to_back();
        repeat (2) @(posedge clk_i);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
cla_pkg.sv
cla_add_if.sv
cla_wb_regs.sv
cla_lookahead_adder.sv
cla_saturate.sv
cla_wb_top.sv
cla_wb_top_sva.sv
tb_cla_wb_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cla_wb_top
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = RESULT: FAIL

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM)
	@$(SIM) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
